/* source/kv_pkg.sv */
// Sizes and address map are fixed; the 12-bit address space holds no other registers
`default_nettype none

package kv_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int unsigned KV_DEPTH  = 8;
    localparam int unsigned KV_DWORDS = 12;
    localparam int unsigned ADDR_W    = 12;

    // ------------------------------------------------------------
    // Plain vectors
    // ------------------------------------------------------------
    typedef logic [31:0]                   dword_t;
    typedef logic [ADDR_W-1:0]             addr_t;
    typedef logic [$clog2(KV_DEPTH)-1:0]   slot_idx_t;
    typedef logic [3:0]                    dword_idx_t;
    typedef logic [KV_DEPTH-1:0]           slot_vec_t;
    typedef logic [7:0]                    dest_t;
    typedef logic [3:0]                    last_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    localparam addr_t CTRL_BASE    = 12'h000; // One ctrl word per slot
    localparam addr_t ENTRY_BASE   = 12'h600;
    localparam addr_t ENTRY_STRIDE = 12'h030; // 12 dwords of 4 bytes

    // Read index for an address outside both maps
    localparam dword_idx_t DWORD_NONE = 4'hf;

    // Control register layout
    localparam int unsigned LOCK_WR_BIT  = 0;
    localparam int unsigned LOCK_USE_BIT = 1;
    localparam int unsigned CLEAR_BIT    = 2;
    localparam int unsigned DEST_LSB     = 9;
    localparam int unsigned LAST_LSB     = 17;

    // ------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------
    typedef struct packed {
        dword_t [KV_DWORDS-1:0] dw;
    } kv_key_t;

    typedef struct packed {
        logic   req;
        logic   is_wr;
        addr_t  addr;
        dword_t wr_data;
        dword_t wr_biten;
    } cpu_req_t;

    typedef struct packed {
        logic   rd_ack;
        dword_t rd_data;
        logic   wr_ack;
    } cpu_rsp_t;

    typedef struct packed {
        slot_vec_t  ctrl_hit;  // One-hot, gated by req
        slot_vec_t  entry_hit;
        dword_idx_t dword;
        logic       is_wr;
        dword_t     wr_data;
        dword_t     wr_biten;
    } sw_access_t;

    typedef struct packed {
        logic       we;
        slot_idx_t  slot;
        dword_idx_t dword;
        dword_t     data;
    } hw_key_wr_t;

    typedef struct packed {
        logic      we;
        slot_idx_t slot;
        dest_t     dest_valid;
        last_t     last_dword;
    } hw_meta_wr_t;

    typedef struct packed {
        logic  lock_wr;
        logic  lock_use;
        dest_t dest_valid;
        last_t last_dword;
    } slot_status_t;

endpackage

`default_nettype wire

/* source/kv_addr_decode.sv */
// Purely combinational; only word-aligned addresses hit, everything else reads as unmapped
`timescale 1ns/10ps
`default_nettype none

module kv_addr_decode (
    input  wire kv_pkg::cpu_req_t    req,
    output kv_pkg::sw_access_t       acc,
    output logic                     wr_ack,
    output logic                     rd_ack,
    output logic                     rd_key_sel,
    output kv_pkg::slot_idx_t        rd_slot,
    output kv_pkg::dword_idx_t       rd_dword
);
    import kv_pkg::*;

    slot_vec_t  ctrl_hit;
    slot_vec_t  entry_hit;
    slot_idx_t  hit_slot;
    dword_idx_t hit_dword;

    // ------------------------------------------------------------
    // Map compare
    // ------------------------------------------------------------
    always_comb begin
        ctrl_hit  = '0;
        entry_hit = '0;
        hit_slot  = '0;
        hit_dword = '0;
        for (int s = 0; s < KV_DEPTH; s++) begin
            if (req.addr == addr_t'(CTRL_BASE + s * 4)) begin
                ctrl_hit[s] = req.req;
                hit_slot    = slot_idx_t'(s);
            end
            for (int d = 0; d < KV_DWORDS; d++) begin
                if (req.addr == addr_t'(ENTRY_BASE + s * ENTRY_STRIDE + d * 4)) begin
                    entry_hit[s] = req.req;
                    hit_slot     = slot_idx_t'(s);
                    hit_dword    = dword_idx_t'(d);
                end
            end
        end
    end

    assign acc.ctrl_hit  = ctrl_hit;
    assign acc.entry_hit = entry_hit;
    assign acc.dword     = hit_dword;
    assign acc.is_wr     = req.is_wr;
    assign acc.wr_data   = req.wr_data;
    assign acc.wr_biten  = req.wr_biten;

    // Every request is acknowledged at once, mapped or not
    assign wr_ack = req.req & req.is_wr;
    assign rd_ack = req.req & ~req.is_wr;

    // Read select for the readback mux
    assign rd_key_sel = rd_ack & (|entry_hit);
    assign rd_slot    = hit_slot;
    assign rd_dword   = (|ctrl_hit)  ? '0 :
                        (|entry_hit) ? hit_dword : DWORD_NONE;

    // Control and key maps must not overlap
    always_comb begin
        a_one_map: assert final (!((|ctrl_hit) && (|entry_hit)))
            else $error("address hits both the control and key dword maps");
    end

endmodule

`default_nettype wire

/* source/kv_slot.sv */
// One slot; lock_wr blocks CPU and HW key writes, the clear bit and metadata stay writable
`timescale 1ns/10ps
`default_nettype none

module kv_slot #(
    parameter kv_pkg::slot_idx_t SLOT_ID = '0
) (
    input  wire                        clk,
    input  wire                        hwif_in,
    input  wire kv_pkg::sw_access_t    acc,
    input  wire kv_pkg::hw_key_wr_t    hw_key,
    input  wire kv_pkg::hw_meta_wr_t   hw_meta,
    input  wire                        hw_clear,
    output kv_pkg::slot_status_t       status,
    output kv_pkg::kv_key_t            key,
    output logic                       clear_pulse
);
    import kv_pkg::*;

    logic    lock_wr_q;
    logic    lock_use_q;
    logic    clear_q;
    dest_t   dest_q;
    last_t   last_q;
    kv_key_t key_q;

    logic ctrl_wr;
    logic lock_wr_ok;
    logic entry_wr;
    logic hw_key_hit;
    logic hw_meta_hit;

    assign ctrl_wr     = acc.ctrl_hit[SLOT_ID] & acc.is_wr;
    assign lock_wr_ok  = ctrl_wr & ~lock_wr_q;
    assign entry_wr    = acc.entry_hit[SLOT_ID] & acc.is_wr & ~lock_wr_q;
    assign hw_key_hit  = hw_key.we & (hw_key.slot == SLOT_ID) & ~lock_wr_q;
    assign hw_meta_hit = hw_meta.we & (hw_meta.slot == SLOT_ID);

    // ------------------------------------------------------------
    // Control fields
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge hwif_in) begin
        if (!hwif_in) begin
            lock_wr_q  <= 1'b0;
            lock_use_q <= 1'b0;
        end else if (lock_wr_ok) begin
            lock_wr_q  <= (lock_wr_q & ~acc.wr_biten[LOCK_WR_BIT])
                        | (acc.wr_data[LOCK_WR_BIT] & acc.wr_biten[LOCK_WR_BIT]);
            lock_use_q <= (lock_use_q & ~acc.wr_biten[LOCK_USE_BIT])
                        | (acc.wr_data[LOCK_USE_BIT] & acc.wr_biten[LOCK_USE_BIT]);
        end
    end

    // Single pulse, old value never merged back in
    always_ff @(posedge clk or negedge hwif_in) begin
        if (!hwif_in) begin
            clear_q <= 1'b0;
        end else begin
            clear_q <= ctrl_wr & acc.wr_data[CLEAR_BIT] & acc.wr_biten[CLEAR_BIT];
        end
    end

    always_ff @(posedge clk or negedge hwif_in) begin
        if (!hwif_in) begin
            dest_q <= '0;
            last_q <= '0;
        end else if (hw_meta_hit) begin // Metadata write beats clear
            dest_q <= hw_meta.dest_valid;
            last_q <= hw_meta.last_dword;
        end else if (hw_clear) begin
            dest_q <= '0;
            last_q <= '0;
        end
    end

    // ------------------------------------------------------------
    // Key dwords with CPU write over HW write over clear
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge hwif_in) begin
        if (!hwif_in) begin
            key_q <= '0;
        end else begin
            for (int d = 0; d < KV_DWORDS; d++) begin
                if (entry_wr && acc.dword == dword_idx_t'(d)) begin
                    key_q.dw[d] <= (key_q.dw[d] & ~acc.wr_biten)
                                 | (acc.wr_data & acc.wr_biten);
                end else if (hw_key_hit && hw_key.dword == dword_idx_t'(d)) begin
                    key_q.dw[d] <= hw_key.data;
                end else if (hw_clear) begin
                    key_q.dw[d] <= '0;
                end
            end
        end
    end

    assign status.lock_wr    = lock_wr_q;
    assign status.lock_use   = lock_use_q;
    assign status.dest_valid = dest_q;
    assign status.last_dword = last_q;
    assign key               = key_q;
    assign clear_pulse       = clear_q;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Locked slot holds its key against HW writes
    a_hw_locked: assert property (
        @(posedge clk) disable iff (!hwif_in)
        (hw_key.we && hw_key.slot == SLOT_ID && lock_wr_q && !hw_clear) |=> $stable(key_q)
    ) else $error("slot %0d key changed by a HW write while locked", SLOT_ID);

    a_pulse_once: assert property (
        @(posedge clk) disable iff (!hwif_in)
        clear_q |=> !clear_q
    ) else $error("slot %0d clear pulse held for two cycles", SLOT_ID);

endmodule

`default_nettype wire

/* source/kv_readback.sv */
// Combinational muxes; key port dword indices past the last key dword read as 0
`timescale 1ns/10ps
`default_nettype none

module kv_readback (
    input  wire kv_pkg::slot_status_t [kv_pkg::KV_DEPTH-1:0] status,
    input  wire kv_pkg::kv_key_t      [kv_pkg::KV_DEPTH-1:0] keys,
    input  wire kv_pkg::slot_vec_t                           pulses,
    input  wire                                              rd_ack,
    input  wire                                              rd_key_sel,
    input  wire kv_pkg::slot_idx_t                           rd_slot,
    input  wire kv_pkg::dword_idx_t                          rd_dword,
    output kv_pkg::dword_t                                   rd_data,
    input  wire kv_pkg::slot_idx_t                           key_rd_slot,
    input  wire kv_pkg::dword_idx_t                          key_rd_dword,
    output kv_pkg::dword_t                                   key_rd_data
);
    import kv_pkg::*;

    dword_t ctrl_word;

    // ------------------------------------------------------------
    // CPU side
    // ------------------------------------------------------------
    always_comb begin
        ctrl_word                           = '0; // Unused fields read 0
        ctrl_word[LOCK_WR_BIT]              = status[rd_slot].lock_wr;
        ctrl_word[LOCK_USE_BIT]             = status[rd_slot].lock_use;
        ctrl_word[CLEAR_BIT]                = pulses[rd_slot];
        ctrl_word[DEST_LSB +: $bits(dest_t)] = status[rd_slot].dest_valid;
        ctrl_word[LAST_LSB +: $bits(last_t)] = status[rd_slot].last_dword;
    end

    always_comb begin
        rd_data = '0;
        if (rd_ack) begin
            if (rd_key_sel) begin
                rd_data = keys[rd_slot].dw[rd_dword];
            end else if (rd_dword != DWORD_NONE) begin
                rd_data = ctrl_word;
            end
        end
    end

    // ------------------------------------------------------------
    // Crypto engine side
    // ------------------------------------------------------------
    assign key_rd_data = (key_rd_dword < KV_DWORDS) ?
                         keys[key_rd_slot].dw[key_rd_dword] : '0;

endmodule

`default_nettype wire

/* source/kv_vault_top.sv */
// Key vault top; single active-low async reset, no stalls and no error responses
`timescale 1ns/10ps
`default_nettype none

module kv_vault_top (
    input  wire                                              clk,
    input  wire                                              hwif_in,
    input  wire kv_pkg::cpu_req_t                            cpu_req,
    output wire kv_pkg::cpu_rsp_t                            cpu_rsp,
    input  wire kv_pkg::hw_key_wr_t                          hw_key,
    input  wire kv_pkg::hw_meta_wr_t                         hw_meta,
    input  wire kv_pkg::slot_vec_t                           hw_clear,
    input  wire kv_pkg::slot_idx_t                           key_rd_slot,
    input  wire kv_pkg::dword_idx_t                          key_rd_dword,
    output wire kv_pkg::dword_t                              key_rd_data,
    output wire kv_pkg::slot_status_t [kv_pkg::KV_DEPTH-1:0] status,
    output wire kv_pkg::slot_vec_t                           clear_pulse
);
    import kv_pkg::*;

    sw_access_t                 acc;
    logic                       rd_key_sel;
    slot_idx_t                  rd_slot;
    dword_idx_t                 rd_dword;
    wire kv_key_t [KV_DEPTH-1:0] keys;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    kv_addr_decode u_decode (
        .req        (cpu_req),
        .acc        (acc),
        .wr_ack     (cpu_rsp.wr_ack),
        .rd_ack     (cpu_rsp.rd_ack),
        .rd_key_sel (rd_key_sel),
        .rd_slot    (rd_slot),
        .rd_dword   (rd_dword)
    );

    // ------------------------------------------------------------
    // Slots
    // ------------------------------------------------------------
    for (genvar g = 0; g < KV_DEPTH; g++) begin : g_slot
        kv_slot #(
            .SLOT_ID (slot_idx_t'(g))
        ) u_slot (
            .clk         (clk),
            .hwif_in     (hwif_in),
            .acc         (acc),
            .hw_key      (hw_key),
            .hw_meta     (hw_meta),
            .hw_clear    (hw_clear[g]),
            .status      (status[g]),
            .key         (keys[g]),
            .clear_pulse (clear_pulse[g])
        );
    end

    // ------------------------------------------------------------
    // Readback
    // ------------------------------------------------------------
    kv_readback u_readback (
        .status       (status),
        .keys         (keys),
        .pulses       (clear_pulse),
        .rd_ack       (cpu_rsp.rd_ack),
        .rd_key_sel   (rd_key_sel),
        .rd_slot      (rd_slot),
        .rd_dword     (rd_dword),
        .rd_data      (cpu_rsp.rd_data),
        .key_rd_slot  (key_rd_slot),
        .key_rd_dword (key_rd_dword),
        .key_rd_data  (key_rd_data)
    );

endmodule

`default_nettype wire

/* test/kv_vault_tb.sv */
// Reads test/kv_vault_golden.txt relative to the project root; one operation per clock cycle
`timescale 1ns/10ps
`default_nettype none

module kv_vault_tb;
    import kv_pkg::*;

    localparam int unsigned FIELDS   = 6;  // op a b c d exp
    localparam int unsigned MAX_OPS  = 64;
    localparam int unsigned ACK_POLL = 4;  // Polled in 1 ns steps before the sampling edge
    localparam logic [31:0] OP_END   = 32'hf;

    logic                                   clk;
    logic                                   hwif_in;
    cpu_req_t                               cpu_req;
    wire cpu_rsp_t                          cpu_rsp;
    hw_key_wr_t                             hw_key;
    hw_meta_wr_t                            hw_meta;
    slot_vec_t                              hw_clear;
    slot_idx_t                              key_rd_slot;
    dword_idx_t                             key_rd_dword;
    wire dword_t                            key_rd_data;
    wire slot_status_t [KV_DEPTH-1:0]       status;
    wire slot_vec_t                         clear_pulse;

    dword_t golden [FIELDS*MAX_OPS];
    int     errors;
    int     timeouts;
    int     checks;

    kv_vault_top UUT (
        .clk          (clk),
        .hwif_in      (hwif_in),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .hw_key       (hw_key),
        .hw_meta      (hw_meta),
        .hw_clear     (hw_clear),
        .key_rd_slot  (key_rd_slot),
        .key_rd_dword (key_rd_dword),
        .key_rd_data  (key_rd_data),
        .status       (status),
        .clear_pulse  (clear_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------
    task automatic drive_idle();
        cpu_req      <= '0;
        hw_key       <= '0;
        hw_meta      <= '0;
        hw_clear     <= '0;
        key_rd_slot  <= '0;
        key_rd_dword <= '0;
    endtask

    task automatic drive_cpu(input logic is_wr, input dword_t addr, input dword_t data,
                             input dword_t biten);
        dword_t fill;
        fill = $urandom();  // Lands only on disabled bits
        cpu_req.req      <= 1'b1;
        cpu_req.is_wr    <= is_wr;
        cpu_req.addr     <= addr_t'(addr);
        cpu_req.wr_data  <= (data & biten) | (fill & ~biten);
        cpu_req.wr_biten <= biten;
    endtask

    // Ack is combinational, so it must show up well inside the request cycle
    task automatic wait_ack(input logic is_wr);
        logic seen;
        seen = 1'b0;
        for (int t = 0; t < ACK_POLL && !seen; t++) begin
            #1;
            seen = is_wr ? cpu_rsp.wr_ack : cpu_rsp.rd_ack;
        end
        if (!seen) begin
            timeouts++;
            $display("Timed out at %0t ns waiting for the %s acknowledge", $time,
                     is_wr ? "write" : "read");
        end
    endtask

    task automatic check_value(input string what, input dword_t got, input dword_t exp);
        checks++;
        a_value: assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s gave 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // One golden line
    // ------------------------------------------------------------
    task automatic run_op(input int n);
        dword_t       op;
        dword_t       a;
        dword_t       b;
        dword_t       c;
        dword_t       d;
        dword_t       exp;
        slot_status_t st;
        op  = golden[n*FIELDS];
        a   = golden[n*FIELDS+1];
        b   = golden[n*FIELDS+2];
        c   = golden[n*FIELDS+3];
        d   = golden[n*FIELDS+4];
        exp = golden[n*FIELDS+5];

        @(posedge clk);
        drive_idle();
        case (op)
            1, 6: drive_cpu(1'b1, a, b, c);
            2:    drive_cpu(1'b0, a, '0, '0);
            3: begin
                hw_key.we    <= 1'b1;
                hw_key.slot  <= slot_idx_t'(a);
                hw_key.dword <= dword_idx_t'(b);
                hw_key.data  <= c;
            end
            4: begin
                hw_meta.we         <= 1'b1;
                hw_meta.slot       <= slot_idx_t'(a);
                hw_meta.dest_valid <= dest_t'(b);
                hw_meta.last_dword <= last_t'(c);
            end
            7: begin
                key_rd_slot  <= slot_idx_t'(a);
                key_rd_dword <= dword_idx_t'(b);
            end
            default: ;
        endcase
        if (op == 5 || op == 6) hw_clear <= slot_vec_t'(d);

        if (op == 1 || op == 6) wait_ack(1'b1);
        else if (op == 2) wait_ack(1'b0);

        @(negedge clk);  // Combinational outputs settled here
        st = status[a[2:0]];
        case (op)
            2: check_value($sformatf("read of 0x%03h", a[11:0]), cpu_rsp.rd_data, exp);
            7: check_value($sformatf("key port slot %0d dword %0d", a, b), key_rd_data, exp);
            8: check_value("clear_pulse", {24'b0, clear_pulse}, exp);
            9: check_value($sformatf("status of slot %0d", a),
                           {18'b0, st.lock_wr, st.lock_use, st.dest_valid, st.last_dword},
                           exp);
            default: ;
        endcase
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int n;
        void'($urandom(52));
        errors       = 0;
        timeouts     = 0;
        checks       = 0;
        hwif_in      = 1'b0;
        cpu_req      = '0;
        hw_key       = '0;
        hw_meta      = '0;
        hw_clear     = '0;
        key_rd_slot  = '0;
        key_rd_dword = '0;

        for (int i = 0; i < FIELDS*MAX_OPS; i++) begin
            golden[i] = OP_END;  // Missing lines end the run
        end
        $readmemh("test/kv_vault_golden.txt", golden);

        repeat (3) @(posedge clk);
        hwif_in <= 1'b1;

        n = 0;
        while (n < MAX_OPS && golden[n*FIELDS] != OP_END) begin
            run_op(n);
            n++;
        end
        if (n == 0) begin
            errors++;
            $display("No operations were read from the golden file");
        end

        $display("Ran %0d operations: %0d checks, %0d errors, %0d timeouts",
                 n, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/kv_vault_golden.txt */
// Columns op a b c d exp in hex. 1 cpu wr a=addr b=data c=biten, 2 cpu rd a=addr, 3 hw key a=slot b=dword c=data
// 4 meta a=slot b=dest c=last, 5 clear d=mask, 6 clear+cpu wr, 7 key port a=slot b=dword, 8 pulses, 9 status a=slot
1 600 12345678 ffffffff 0 0
1 600 aabbccdd 0000ffff 0 0
2 600 0 0 0 1234ccdd
1 6b4 cafebabe ff00ff00 0 0
2 6b4 0 0 0 ca00ba00
1 77c deadbeef f0f0f0f0 0 0
2 77c 0 0 0 d0a0b0e0
3 1 2 0badf00d 0 0
2 638 0 0 0 0badf00d
7 1 2 0 0 0badf00d
4 1 a5 b 0 0
2 004 0 0 0 00174a00
9 1 0 0 0 a5b
1 660 11112222 ffffffff 0 0
1 008 3 3 0 0
1 660 ffffffff ffffffff 0 0
3 2 0 55555555 0 0
1 008 0 3 0 0
2 660 0 0 0 11112222
7 2 0 0 0 11112222
9 2 0 0 0 3000
1 604 87654321 ffffffff 0 0
2 604 0 0 0 87654321
1 014 4 4 0 0
8 0 0 0 0 20
8 0 0 0 0 0
2 014 0 0 0 0
1 008 4 4 0 0
2 008 0 0 0 7
8 0 0 0 0 0
1 630 aaaa5555 ffffffff 0 0
6 634 77777777 ffffffff 2 0
2 630 0 0 0 0
2 634 0 0 0 77777777
7 1 2 0 0 0
9 1 0 0 0 0
5 0 0 0 4 0
9 2 0 0 0 3000
2 660 0 0 0 0
2 100 0 0 0 0
2 602 0 0 0 0
2 780 0 0 0 0
1 200 ffffffff ffffffff 0 0
f 0 0 0 0 0

/* kv_vault.f */
source/kv_pkg.sv
source/kv_addr_decode.sv
source/kv_slot.sv
source/kv_readback.sv
source/kv_vault_top.sv
test/kv_vault_tb.sv

/* Bender.yml */
package:
  name: kv_vault

sources:
  - files:
      - source/kv_pkg.sv
      - source/kv_addr_decode.sv
      - source/kv_slot.sv
      - source/kv_readback.sv
      - source/kv_vault_top.sv
  - target: test
    files:
      - test/kv_vault_tb.sv
